/* csr_params.svh */
// machine csr parameters
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// widths
`define CSR_XLEN 32            // data word
`define CSR_AW   12            // csr address field

// machine csr addresses
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12

// fixed csr contents
`define MSTATUS_VAL   32'h0000_1800   // mpp = machine
`define MVENDORID_VAL 32'h4353_5255
`define MARCHID_VAL   32'h0000_0017

`define CAUSE_ECALL_M 4'hb            // ecall from m-mode
`define OPC_SYSTEM    7'b1110011
`define IMM_MRET      12'h302         // csr field of mret
`endif

/* csr_pkg.sv */
// csr unit types
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

  // one architectural data word
  typedef logic [`CSR_XLEN-1:0] xlen_t;

  // csr address, inst[31:20]
  typedef logic [`CSR_AW-1:0] csr_addr_t;

  // csr operation select, inst[14:12]
  // bit 2 picks the zimm source
  // bits 1:0 pick rw / rs / rc
  typedef logic [2:0] funct3_t;

  // stored part of mcause
  // only the exception code is kept, no interrupt bit
  typedef logic [3:0] cause_t;

endpackage

`default_nettype wire

/* csr_bus_if.sv */
// execute to csr file bus
`default_nettype none

interface csr_bus_if
  import csr_pkg::*;
();

  // read port, combinational
  csr_addr_t raddr;
  xlen_t     rdata;

  // write port, commits on next clk edge
  logic      wen;
  csr_addr_t waddr;
  xlen_t     wdata;

  // trap capture, wins over wen
  logic      trap;
  xlen_t     trap_pc;           // goes to mepc

  // live register values for redirects
  xlen_t     mtvec;
  xlen_t     mepc;

  modport exec (output raddr, wen, waddr, wdata, trap, trap_pc,
                input  rdata, mtvec, mepc);

  modport file (input  raddr, wen, waddr, wdata, trap, trap_pc,
                output rdata, mtvec, mepc);

endinterface

`default_nettype wire

/* csr_file.sv */
// machine csr register block
`default_nettype none

`include "csr_params.svh"

module csr_file
  import csr_pkg::*;
(
  input logic   clk,
  input logic   rst,
  csr_bus_if.file bus
);

  // only the writable trap csrs get flops
  xlen_t  mtvec_q;
  xlen_t  mepc_q;
  cause_t mcause_q;

  // write and trap capture
  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec_q  <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (bus.trap) begin       // trap has priority over a write
      mepc_q   <= bus.trap_pc;
      mcause_q <= `CAUSE_ECALL_M;
    end else if (bus.wen) begin
      case (bus.waddr)
        `CSR_MTVEC:  mtvec_q  <= bus.wdata;
        `CSR_MEPC:   mepc_q   <= bus.wdata;
        `CSR_MCAUSE: mcause_q <= bus.wdata[3:0];  // low code bits only
        default: ;                     // constants and unknown are dropped
      endcase
    end
  end

  // read decode
  always_comb begin
    case (bus.raddr)
      `CSR_MSTATUS:   bus.rdata = `MSTATUS_VAL;
      `CSR_MTVEC:     bus.rdata = mtvec_q;
      `CSR_MEPC:      bus.rdata = mepc_q;
      `CSR_MCAUSE:    bus.rdata = {{(`CSR_XLEN-4){1'b0}}, mcause_q};  // zero ext
      `CSR_MVENDORID: bus.rdata = `MVENDORID_VAL;
      `CSR_MARCHID:   bus.rdata = `MARCHID_VAL;
      default:        bus.rdata = '0;  // unimplemented reads as zero
    endcase
  end

  // live values for the redirect mux in exec
  assign bus.mtvec = mtvec_q;
  assign bus.mepc  = mepc_q;

  // mcause comes out of reset cleared
  a_mcause_reset: assert property (
    @(posedge clk) rst |=> (mcause_q == '0)
  ) else $error("mcause not cleared by reset");

  // exec must never ask for a write in a trap cycle
  a_no_trap_and_write: assert property (
    @(posedge clk) disable iff (rst) !(bus.trap && bus.wen)
  ) else $error("trap and csr write in the same cycle");

endmodule

`default_nettype wire

/* csr_exec.sv */
// system instruction execute stage
`default_nettype none

`include "csr_params.svh"

module csr_exec
  import csr_pkg::*;
(
  input  logic  clk,                 // assertion clocking only
  input  logic  rst,
  input  logic  valid,
  input  xlen_t inst,
  input  xlen_t rs1_data,
  input  xlen_t pc,
  output xlen_t rd_data,
  output logic  rd_we,
  output logic  redirect,
  output xlen_t redirect_pc,
  output logic  illegal,
  csr_bus_if.exec bus
);

  // instruction fields
  logic [6:0] opcode;
  funct3_t    funct3;
  logic [4:0] rs1_f;                 // rs1 index or zimm
  csr_addr_t  csr_addr;

  // decoded kinds
  logic is_sys;
  logic is_csr;
  logic is_ecall;
  logic is_mret;

  // read-modify-write path
  xlen_t src;
  xlen_t new_val;
  logic  wr_req;                     // operation wants to write
  logic  ro_addr;                    // addr in read-only space

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_f    = inst[19:15];
  assign csr_addr = inst[31:20];

  assign is_sys   = valid && (opcode == `OPC_SYSTEM);
  assign is_csr   = is_sys && (funct3 != 3'b000);
  assign is_ecall = is_sys && (funct3 == 3'b000) && (csr_addr == '0);
  assign is_mret  = is_sys && (funct3 == 3'b000) && (csr_addr == `IMM_MRET);

  // zimm form takes the rs1 field itself
  assign src = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, rs1_f} : rs1_data;

  // old value comes straight back from the file
  always_comb begin
    case (funct3[1:0])
      2'b01: begin                   // csrrw
        new_val = src;
        wr_req  = 1'b1;
      end
      2'b10: begin                   // csrrs
        new_val = bus.rdata | src;
        wr_req  = (rs1_f != 5'd0);   // x0 / zimm 0 is read only
      end
      2'b11: begin                   // csrrc
        new_val = bus.rdata & ~src;
        wr_req  = (rs1_f != 5'd0);
      end
      default: begin                 // reserved, no write
        new_val = bus.rdata;
        wr_req  = 1'b0;
      end
    endcase
  end

  // top two address bits 11 is read-only
  assign ro_addr = (csr_addr[11:10] == 2'b11);

  // bus side
  assign bus.raddr   = csr_addr;
  assign bus.waddr   = csr_addr;
  assign bus.wdata   = new_val;
  assign bus.wen     = is_csr && wr_req && !ro_addr;
  assign bus.trap    = is_ecall;
  assign bus.trap_pc = pc;           // epc is the ecall itself

  // core side
  assign rd_data     = bus.rdata;    // old csr value
  assign rd_we       = is_csr;
  assign illegal     = is_csr && wr_req && ro_addr;
  assign redirect    = is_ecall || is_mret;
  assign redirect_pc = is_ecall ? bus.mtvec : bus.mepc;

  // redirecting instructions never write a gpr
  a_redirect_no_rd: assert property (
    @(posedge clk) disable iff (rst) !(redirect && rd_we)
  ) else $error("redirect together with rd write");

  // a blocked write must not reach the file
  a_illegal_no_wen: assert property (
    @(posedge clk) disable iff (rst) !(bus.wen && illegal)
  ) else $error("csr write issued on illegal access");

endmodule

`default_nettype wire

/* csr_unit_top.sv */
// machine csr unit top
`default_nettype none

`include "csr_params.svh"

module csr_unit_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid,        // one inst per cycle
  input  logic [`CSR_XLEN-1:0] inst,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  input  logic [`CSR_XLEN-1:0] pc,
  output logic [`CSR_XLEN-1:0] rd_data,      // old csr value
  output logic                 rd_we,
  output logic                 redirect,     // ecall / mret
  output logic [`CSR_XLEN-1:0] redirect_pc,
  output logic                 illegal       // write to read-only csr
);

  // exec <-> register block
  csr_bus_if bus ();

  // decode and rmw
  csr_exec i_exec (
    .clk         (clk),
    .rst         (rst),
    .valid       (valid),
    .inst        (inst),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .rd_data     (rd_data),
    .rd_we       (rd_we),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal),
    .bus         (bus)
  );

  // trap csrs and constants
  csr_file i_file (
    .clk (clk),
    .rst (rst),
    .bus (bus)
  );

endmodule

`default_nettype wire

/* tb_csr_unit.sv */
// machine csr unit testbench
`default_nettype none

`include "csr_params.svh"

module tb_csr_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;

  logic        clk;
  logic        rst;
  logic        valid;
  logic [31:0] inst;
  logic [31:0] rs1_data;
  logic [31:0] pc;
  logic [31:0] rd_data;
  logic        rd_we;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        illegal;

  // reference copy of the writable csrs
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mepc;
  logic [3:0]  ref_mcause;
  string       test_name;

  csr_unit_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .valid       (valid),
    .inst        (inst),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .rd_data     (rd_data),
    .rd_we       (rd_we),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // SYSTEM encoding with rd fixed at x1
  function automatic logic [31:0] encode_sys(input logic [2:0] f3, input logic [11:0] addr,
                                             input logic [4:0] rs1f);
    return {addr, rs1f, f3, 5'd1, `OPC_SYSTEM};
  endfunction

  // what a read of addr should return
  function automatic logic [31:0] expected_csr(input logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS:   return `MSTATUS_VAL;
      `CSR_MTVEC:     return ref_mtvec;
      `CSR_MEPC:      return ref_mepc;
      `CSR_MCAUSE:    return {28'd0, ref_mcause};
      `CSR_MVENDORID: return `MVENDORID_VAL;
      `CSR_MARCHID:   return `MARCHID_VAL;
      default:        return 32'd0;   // unknown reads zero
    endcase
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      `CSR_MTVEC:  ref_mtvec  = val;
      `CSR_MEPC:   ref_mepc   = val;
      `CSR_MCAUSE: ref_mcause = val[3:0];   // only the code bits stick
      default: ;
    endcase
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch in %s", test_name);
    end
  endtask

  // drive on falling edge and let outputs settle 1 ns
  task automatic issue(input logic [31:0] i, input logic [31:0] r, input logic [31:0] p);
    @(negedge clk);
    valid    = 1'b1;
    inst     = i;
    rs1_data = r;
    pc       = p;
    #1;
  endtask

  // csrrs with rs1 field zero and junk in rs1_data
  task automatic read_check(input logic [11:0] addr, input string what);
    issue(encode_sys(3'b010, addr, 5'd0), $urandom, 32'd0);
    check_val(what, expected_csr(addr), rd_data);
    check_val({what, " rd_we"}, 32'd1, 32'(rd_we));
    check_val({what, " illegal"}, 32'd0, 32'(illegal));
    check_val({what, " redirect"}, 32'd0, 32'(redirect));
  endtask

  task automatic reset_and_constants();
    test_name = "reset_consts";
    read_check(`CSR_MTVEC, "mtvec");
    read_check(`CSR_MEPC, "mepc");
    read_check(`CSR_MCAUSE, "mcause");
    read_check(`CSR_MSTATUS, "mstatus");
    read_check(`CSR_MVENDORID, "mvendorid");
    read_check(`CSR_MARCHID, "marchid");
    read_check(12'h7c0, "unknown");
    read_check(`CSR_MTVEC, "mtvec unchanged");   // x0 reads wrote nothing
  endtask

  task automatic rw_one(input logic [11:0] addr);
    logic [31:0] v;
    logic [4:0]  z;
    v = $urandom;
    z = 5'($urandom);
    issue(encode_sys(3'b001, addr, 5'd5), v, 32'd0);        // csrrw
    check_val("csrrw old", expected_csr(addr), rd_data);
    model_write(addr, v);
    read_check(addr, "csrrw new");
    issue(encode_sys(3'b101, addr, z), $urandom, 32'd0);    // csrrwi ignores rs1_data
    check_val("csrrwi old", expected_csr(addr), rd_data);
    model_write(addr, {27'd0, z});
    read_check(addr, "csrrwi new");
  endtask

  task automatic write_and_readback();
    test_name = "csrrw";
    rw_one(`CSR_MTVEC);
    rw_one(`CSR_MEPC);
    rw_one(`CSR_MCAUSE);
  endtask

  task automatic set_clear_one(input logic [11:0] addr);
    logic [31:0] mask;
    mask = $urandom;
    issue(encode_sys(3'b010, addr, 5'd7), mask, 32'd0);     // csrrs
    check_val("csrrs old", expected_csr(addr), rd_data);
    model_write(addr, expected_csr(addr) | mask);
    read_check(addr, "after set");
    mask = $urandom;
    issue(encode_sys(3'b011, addr, 5'd9), mask, 32'd0);     // csrrc
    check_val("csrrc old", expected_csr(addr), rd_data);
    model_write(addr, expected_csr(addr) & ~mask);
    read_check(addr, "after clear");
    issue(encode_sys(3'b011, addr, 5'd0), 32'hffff_ffff, 32'd0);  // x0 source means no write
    read_check(addr, "rs1 zero unchanged");
  endtask

  task automatic set_and_clear();
    test_name = "set_clear";
    set_clear_one(`CSR_MTVEC);
    set_clear_one(`CSR_MEPC);
    set_clear_one(`CSR_MCAUSE);
  endtask

  task automatic ecall_trap();
    logic [31:0] epc;
    test_name = "ecall";
    epc = $urandom & 32'hffff_fffc;
    issue(encode_sys(3'b001, `CSR_MTVEC, 5'd2), 32'h0000_0400, 32'd0);
    model_write(`CSR_MTVEC, 32'h0000_0400);
    issue(32'h0000_0073, $urandom, epc);
    check_val("redirect", 32'd1, 32'(redirect));
    check_val("redirect_pc", ref_mtvec, redirect_pc);
    check_val("rd_we", 32'd0, 32'(rd_we));
    check_val("illegal", 32'd0, 32'(illegal));
    ref_mepc   = epc;             // trap capture
    ref_mcause = `CAUSE_ECALL_M;
    read_check(`CSR_MEPC, "mepc");
    read_check(`CSR_MCAUSE, "mcause");
  endtask

  task automatic mret_return();
    test_name = "mret";
    issue(32'h3020_0073, $urandom, $urandom);
    check_val("redirect", 32'd1, 32'(redirect));
    check_val("redirect_pc", ref_mepc, redirect_pc);
    check_val("rd_we", 32'd0, 32'(rd_we));
    read_check(`CSR_MTVEC, "mtvec");
    read_check(`CSR_MEPC, "mepc");
    read_check(`CSR_MCAUSE, "mcause");
  endtask

  task automatic illegal_write();
    test_name = "illegal";
    issue(encode_sys(3'b001, `CSR_MVENDORID, 5'd3), $urandom, 32'd0);
    check_val("illegal", 32'd1, 32'(illegal));
    check_val("old value", `MVENDORID_VAL, rd_data);
    read_check(`CSR_MVENDORID, "mvendorid kept");   // plain read is legal
  endtask

  // run limit scaled by test count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h669a));
    clk        = 1'b0;
    rst        = 1'b1;
    valid      = 1'b0;
    inst       = '0;
    rs1_data   = '0;
    pc         = '0;
    ref_mtvec  = '0;
    ref_mepc   = '0;
    ref_mcause = '0;
    test_name  = "init";
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_and_constants();
    write_and_readback();
    set_and_clear();
    ecall_trap();
    mret_return();
    illegal_write();
    @(negedge clk);
    valid = 1'b0;
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
csr_pkg.sv
csr_bus_if.sv
csr_file.sv
csr_exec.sv
csr_unit_top.sv
tb_csr_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_csr_unit
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
